//--- logic/debug_csr_pkg.sv
package debug_csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  priv_t;

    // Privilege encodings with 2 reserved
    localparam priv_t PRV_U    = 2'd0;
    localparam priv_t PRV_S    = 2'd1;
    localparam priv_t PRV_RSVD = 2'd2;
    localparam priv_t PRV_M    = 2'd3;

    // Debug CSR addresses
    localparam csr_addr_t DCSR_ADDR      = 12'h7b0;
    localparam csr_addr_t DPC_ADDR       = 12'h7b1;
    localparam csr_addr_t DSCRATCH0_ADDR = 12'h7b2;
    localparam csr_addr_t DSCRATCH1_ADDR = 12'h7b3;

    // dcsr.cause values
    localparam logic [2:0] CAUSE_EBREAK  = 3'd1;
    localparam logic [2:0] CAUSE_HALTREQ = 3'd3;
    localparam logic [2:0] CAUSE_STEP    = 3'd4;

    localparam logic [3:0] XDEBUGVER = 4'd4;

    typedef struct packed {
        logic [3:0]  xdebugver;
        logic [11:0] rsvd_27_16;
        logic        ebreakm;
        logic        rsvd_14;
        logic        ebreaks;
        logic        ebreaku;
        logic        stepie;
        logic        stopcount;
        logic        stoptime;
        logic [2:0]  cause;
        logic        rsvd_5;
        logic        mprven;
        logic        nmip;
        logic        step;
        priv_t       prv;
    } dcsr_t;

    // Same 32 bits seen as a data word or as the dcsr layout
    typedef union packed {
        word_t raw;
        dcsr_t dcsr;
    } csr_word_u;

    typedef struct packed {
        csr_addr_t addr;
        word_t     wdata;
        logic      write;
        logic      valid;
    } csr_req_t;

    typedef struct packed {
        logic  wr_dcsr;
        logic  wr_dpc;
        logic  wr_dscratch0;
        logic  wr_dscratch1;
        word_t wdata;
    } csr_wr_t;

    typedef struct packed {
        logic  valid;
        logic  ack;
        logic  invalid;
        word_t rdata;
    } csr_rsp_t;

    // Pipeline event pulses with current PC and privilege
    typedef struct packed {
        logic  ebreak;
        logic  step_done;
        logic  dret;
        word_t pc;
        priv_t prv;
    } hart_evt_t;

    typedef struct packed {
        logic       take;
        logic [2:0] cause;
        word_t      pc;
        priv_t      prv;
    } entry_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        priv_t prv;
    } resume_t;

endpackage

//--- logic/csr_access_decode.sv
`timescale 1ns/1ps

module csr_access_decode
    import debug_csr_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  csr_req_t csr_req,
    input  logic     debug_mode,
    output csr_wr_t  csr_wr,
    output logic     rsp_stb,
    output logic     ack,
    output logic     invalid
);

    logic sel_dcsr;
    logic sel_dpc;
    logic sel_dscratch0;
    logic sel_dscratch1;
    logic hit;
    logic wr_ok;

    // Address match against the four debug registers
    always_comb begin
        sel_dcsr      = (csr_req.addr == DCSR_ADDR);
        sel_dpc       = (csr_req.addr == DPC_ADDR);
        sel_dscratch0 = (csr_req.addr == DSCRATCH0_ADDR);
        sel_dscratch1 = (csr_req.addr == DSCRATCH1_ADDR);
        hit           = sel_dcsr | sel_dpc | sel_dscratch0 | sel_dscratch1;
    end

    // Debug CSRs only reachable from debug mode
    assign rsp_stb = csr_req.valid;
    assign ack     = csr_req.valid & hit & debug_mode;
    assign invalid = csr_req.valid & hit & ~debug_mode;
    assign wr_ok   = ack & csr_req.write;

    always_comb begin
        csr_wr.wr_dcsr      = wr_ok & sel_dcsr;
        csr_wr.wr_dpc       = wr_ok & sel_dpc;
        csr_wr.wr_dscratch0 = wr_ok & sel_dscratch0;
        csr_wr.wr_dscratch1 = wr_ok & sel_dscratch1;
        csr_wr.wdata        = csr_req.wdata;
    end

    // At most one register written per request
    a_one_strobe: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0({csr_wr.wr_dcsr, csr_wr.wr_dpc, csr_wr.wr_dscratch0, csr_wr.wr_dscratch1})
    ) else $error("more than one debug CSR write strobe");

endmodule

//--- logic/debug_entry_ctrl.sv
`timescale 1ns/1ps

module debug_entry_ctrl
    import debug_csr_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      halt_req,
    input  hart_evt_t hart_evt,
    input  dcsr_t     dcsr,
    output logic      debug_mode,
    output entry_t    entry,
    output logic      dret_take
);

    logic ebreak_en;
    logic trig_ebreak;
    logic trig_halt;
    logic trig_step;

    // ebreak enable picked by the privilege the hart runs at
    always_comb begin
        case (hart_evt.prv)
            PRV_M:   ebreak_en = dcsr.ebreakm;
            PRV_S:   ebreak_en = dcsr.ebreaks;
            PRV_U:   ebreak_en = dcsr.ebreaku;
            default: ebreak_en = 1'b0;
        endcase
    end

    assign trig_ebreak = hart_evt.ebreak & ebreak_en;
    assign trig_halt   = halt_req;
    assign trig_step   = hart_evt.step_done & dcsr.step;

    // Entry only from normal mode with ebreak over haltreq over step
    always_comb begin
        entry.take = ~debug_mode & (trig_ebreak | trig_halt | trig_step);
        if (trig_ebreak) begin
            entry.cause = CAUSE_EBREAK;
        end else if (trig_halt) begin
            entry.cause = CAUSE_HALTREQ;
        end else begin
            entry.cause = CAUSE_STEP;
        end
        entry.pc  = hart_evt.pc;
        entry.prv = hart_evt.prv;
    end

    // dret outside debug mode is dropped
    assign dret_take = debug_mode & hart_evt.dret;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            debug_mode <= 1'b0;
        end else if (entry.take) begin
            debug_mode <= 1'b1;
        end else if (dret_take) begin
            debug_mode <= 1'b0;
        end
    end

    a_entry_vs_exit: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(entry.take && dret_take)
    ) else $error("debug entry and dret in the same cycle");

endmodule

//--- logic/debug_csr_file.sv
`timescale 1ns/1ps

module debug_csr_file
    import debug_csr_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  csr_wr_t csr_wr,
    input  entry_t  entry,
    output dcsr_t   dcsr,
    output word_t   dpc,
    output word_t   dscratch0,
    output word_t   dscratch1
);

    csr_word_u wr_word;

    // Write value decoded as dcsr fields
    assign wr_word.raw = csr_wr.wdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dcsr           <= '0;
            dcsr.xdebugver <= XDEBUGVER;
            dcsr.prv       <= PRV_M;
        end else if (entry.take) begin
            dcsr.cause <= entry.cause;
            dcsr.prv   <= entry.prv;
        end else if (csr_wr.wr_dcsr) begin
            // Only the ebreak enables, step and prv are writable
            dcsr.ebreakm <= wr_word.dcsr.ebreakm;
            dcsr.ebreaks <= wr_word.dcsr.ebreaks;
            dcsr.ebreaku <= wr_word.dcsr.ebreaku;
            dcsr.step    <= wr_word.dcsr.step;
            if (wr_word.dcsr.prv != PRV_RSVD) begin
                dcsr.prv <= wr_word.dcsr.prv;
            end
        end
    end

    // dpc loads the trap PC on entry and otherwise takes debugger writes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dpc <= '0;
        end else if (entry.take) begin
            dpc <= entry.pc;
        end else if (csr_wr.wr_dpc) begin
            dpc <= csr_wr.wdata;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dscratch0 <= '0;
        end else if (csr_wr.wr_dscratch0) begin
            dscratch0 <= csr_wr.wdata;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dscratch1 <= '0;
        end else if (csr_wr.wr_dscratch1) begin
            dscratch1 <= csr_wr.wdata;
        end
    end

    a_xdebugver: assert property (
        @(posedge CLK) disable iff (!nRST)
        dcsr.xdebugver == XDEBUGVER
    ) else $error("dcsr.xdebugver changed");

endmodule

//--- logic/debug_resp_port.sv
`timescale 1ns/1ps

module debug_resp_port
    import debug_csr_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      rsp_stb,
    input  logic      ack,
    input  logic      invalid,
    input  csr_addr_t csr_addr,
    input  dcsr_t     dcsr,
    input  word_t     dpc,
    input  word_t     dscratch0,
    input  word_t     dscratch1,
    input  logic      dret_take,
    output csr_rsp_t  csr_rsp,
    output resume_t   resume
);

    csr_word_u rd_word;

    // Read mux on the low address bits and zero unless accepted
    always_comb begin
        rd_word.raw = '0;
        if (ack) begin
            case (csr_addr[1:0])
                2'b00:   rd_word.dcsr = dcsr;
                2'b01:   rd_word.raw  = dpc;
                2'b10:   rd_word.raw  = dscratch0;
                default: rd_word.raw  = dscratch1;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            csr_rsp <= '0;
        end else begin
            csr_rsp.valid   <= rsp_stb;
            csr_rsp.ack     <= ack;
            csr_rsp.invalid <= invalid;
            csr_rsp.rdata   <= rd_word.raw;
        end
    end

    // Resume packet captures dpc and prv as of the dret
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resume <= '0;
        end else begin
            resume.valid <= dret_take;
            if (dret_take) begin
                resume.pc  <= dpc;
                resume.prv <= dcsr.prv;
            end
        end
    end

    a_ack_xor_invalid: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(csr_rsp.ack && csr_rsp.invalid)
    ) else $error("response with both ack and invalid");

endmodule

//--- logic/debug_csr_top.sv
`timescale 1ns/1ps

module debug_csr_top
    import debug_csr_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  csr_req_t  csr_req,
    input  logic      halt_req,
    input  hart_evt_t hart_evt,
    output csr_rsp_t  csr_rsp,
    output resume_t   resume,
    output logic      debug_mode
);

    csr_wr_t csr_wr;
    entry_t  entry;
    dcsr_t   dcsr;
    word_t   dpc;
    word_t   dscratch0;
    word_t   dscratch1;
    logic    rsp_stb;
    logic    ack;
    logic    invalid;
    logic    dret_take;

    // Input side
    csr_access_decode i_csr_access_decode (
        .CLK        (CLK),
        .nRST       (nRST),
        .csr_req    (csr_req),
        .debug_mode (debug_mode),
        .csr_wr     (csr_wr),
        .rsp_stb    (rsp_stb),
        .ack        (ack),
        .invalid    (invalid)
    );

    debug_entry_ctrl i_debug_entry_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .halt_req   (halt_req),
        .hart_evt   (hart_evt),
        .dcsr       (dcsr),
        .debug_mode (debug_mode),
        .entry      (entry),
        .dret_take  (dret_take)
    );

    debug_csr_file i_debug_csr_file (
        .CLK       (CLK),
        .nRST      (nRST),
        .csr_wr    (csr_wr),
        .entry     (entry),
        .dcsr      (dcsr),
        .dpc       (dpc),
        .dscratch0 (dscratch0),
        .dscratch1 (dscratch1)
    );

    // Output side
    debug_resp_port i_debug_resp_port (
        .CLK       (CLK),
        .nRST      (nRST),
        .rsp_stb   (rsp_stb),
        .ack       (ack),
        .invalid   (invalid),
        .csr_addr  (csr_req.addr),
        .dcsr      (dcsr),
        .dpc       (dpc),
        .dscratch0 (dscratch0),
        .dscratch1 (dscratch1),
        .dret_take (dret_take),
        .csr_rsp   (csr_rsp),
        .resume    (resume)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    // 8 ns period
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Reset held for 16 cycles and released just after an edge
    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

//--- tests/debug_csr_tb.sv
`timescale 1ns/1ps

module debug_csr_tb
    import debug_csr_pkg::*;
();

    localparam int WAIT_LIMIT = 64;

    logic      CLK;
    logic      nRST;
    csr_req_t  csr_req;
    logic      halt_req;
    hart_evt_t hart_evt;
    csr_rsp_t  csr_rsp;
    resume_t   resume;
    logic      debug_mode;

    // Reference model of the debug registers and mode
    word_t      m_dcsr;
    word_t      m_dpc;
    word_t      m_scratch0;
    word_t      m_scratch1;
    logic       m_mode;
    csr_rsp_t   exp_rsp;
    resume_t    exp_resume;
    logic       m_hit;
    logic       m_acc;
    logic       m_dret;
    logic [2:0] m_cause;
    word_t      m_rdata;

    logic [31:0] lfsr;
    int          errors;
    int          errs_at_start;
    int          tests_run;
    int          tests_failed;
    logic        hung;

    tb_clock_gen i_tb_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    debug_csr_top i_debug_csr_top (
        .CLK        (CLK),
        .nRST       (nRST),
        .csr_req    (csr_req),
        .halt_req   (halt_req),
        .hart_evt   (hart_evt),
        .csr_rsp    (csr_rsp),
        .resume     (resume),
        .debug_mode (debug_mode)
    );

    // ebreakm bit 15, ebreaks bit 13, ebreaku bit 12
    function automatic logic ebreak_allowed(input word_t d, input priv_t prv);
        case (prv)
            2'd3:    return d[15];
            2'd1:    return d[13];
            2'd0:    return d[12];
            default: return 1'b0;
        endcase
    endfunction

    // Writable fields are the ebreak enables, step and prv unless reserved
    function automatic word_t dcsr_write(input word_t old, input word_t wd);
        word_t mask;
        word_t nxt;
        mask = 32'h0000_b004;
        nxt = (old & ~mask) | (wd & mask);
        if (wd[1:0] != 2'd2) begin
            nxt[1:0] = wd[1:0];
        end
        return nxt;
    endfunction

    // Right-shift Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    always_comb begin
        m_hit   = csr_req.valid && (csr_req.addr >= DCSR_ADDR) && (csr_req.addr <= DSCRATCH1_ADDR);
        m_acc   = m_hit && m_mode;
        m_dret  = m_mode && hart_evt.dret;
        m_rdata = '0;
        if (m_acc) begin
            case (csr_req.addr)
                DCSR_ADDR:      m_rdata = m_dcsr;
                DPC_ADDR:       m_rdata = m_dpc;
                DSCRATCH0_ADDR: m_rdata = m_scratch0;
                default:        m_rdata = m_scratch1;
            endcase
        end
        // Zero cause means no trigger
        m_cause = 3'd0;
        if (hart_evt.ebreak && ebreak_allowed(m_dcsr, hart_evt.prv)) begin
            m_cause = CAUSE_EBREAK;
        end else if (halt_req) begin
            m_cause = CAUSE_HALTREQ;
        end else if (hart_evt.step_done && m_dcsr[2]) begin
            m_cause = CAUSE_STEP;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            m_dcsr     <= 32'h4000_0003;
            m_dpc      <= '0;
            m_scratch0 <= '0;
            m_scratch1 <= '0;
            m_mode     <= 1'b0;
            exp_rsp    <= '0;
            exp_resume <= '0;
        end else begin
            exp_rsp.valid    <= csr_req.valid;
            exp_rsp.ack      <= m_acc;
            exp_rsp.invalid  <= m_hit && !m_mode;
            exp_rsp.rdata    <= m_rdata;
            exp_resume.valid <= m_dret;
            if (!m_mode && m_cause != 3'd0) begin
                m_mode      <= 1'b1;
                m_dpc       <= hart_evt.pc;
                m_dcsr[8:6] <= m_cause;
                m_dcsr[1:0] <= hart_evt.prv;
            end else if (m_dret) begin
                m_mode         <= 1'b0;
                exp_resume.pc  <= m_dpc;
                exp_resume.prv <= m_dcsr[1:0];
            end
            if (m_acc && csr_req.write) begin
                case (csr_req.addr)
                    DCSR_ADDR:      m_dcsr <= dcsr_write(m_dcsr, csr_req.wdata);
                    DPC_ADDR:       m_dpc <= csr_req.wdata;
                    DSCRATCH0_ADDR: m_scratch0 <= csr_req.wdata;
                    default:        m_scratch1 <= csr_req.wdata;
                endcase
            end
        end
    end

    // Outputs compared against the model at the falling edge
    a_rsp_flags: assert property (@(negedge CLK) disable iff (!nRST)
        {csr_rsp.valid, csr_rsp.ack, csr_rsp.invalid}
            == {exp_rsp.valid, exp_rsp.ack, exp_rsp.invalid})
    else begin
        errors++;
        $display("error: csr_rsp {valid,ack,invalid} = %h, expected %h",
            {csr_rsp.valid, csr_rsp.ack, csr_rsp.invalid},
            {exp_rsp.valid, exp_rsp.ack, exp_rsp.invalid});
    end

    a_rsp_rdata: assert property (@(negedge CLK) disable iff (!nRST)
        csr_rsp.rdata == exp_rsp.rdata)
    else begin
        errors++;
        $display("error: csr_rsp.rdata = %h, expected %h", csr_rsp.rdata, exp_rsp.rdata);
    end

    a_resume: assert property (@(negedge CLK) disable iff (!nRST)
        resume == exp_resume)
    else begin
        errors++;
        $display("error: resume = %h, expected %h", resume, exp_resume);
    end

    a_mode: assert property (@(negedge CLK) disable iff (!nRST)
        debug_mode == m_mode)
    else begin
        errors++;
        $display("error: debug_mode = %h, expected %h", debug_mode, m_mode);
    end

    a_resume_pulse: assert property (@(negedge CLK) disable iff (!nRST)
        resume.valid |=> !resume.valid)
    else begin
        errors++;
        $display("resume.valid stayed high for more than one cycle");
    end

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        hung = 1'b1;
        errors++;
    endtask

    task automatic begin_test();
        errs_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic rand_word(output word_t w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (!nRST && n < WAIT_LIMIT) begin
            @(posedge CLK);
            n++;
        end
        #1;
        if (!nRST) begin
            report_timeout("reset release");
        end
    endtask

    task automatic wait_mode(input logic want, input string what);
        int n;
        if (hung) begin
            return;
        end
        n = 0;
        while (debug_mode !== want && n < WAIT_LIMIT) begin
            idle_cycles(1);
            n++;
        end
        if (debug_mode !== want) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_resume();
        int n;
        if (hung) begin
            return;
        end
        n = 0;
        while (resume.valid !== 1'b1 && n < WAIT_LIMIT) begin
            idle_cycles(1);
            n++;
        end
        if (resume.valid !== 1'b1) begin
            report_timeout("resume pulse");
        end
    endtask

    // One request strobe followed by a wait for its response
    task automatic csr_access(input csr_addr_t addr, input logic wr, input word_t wdata);
        int n;
        if (hung) begin
            return;
        end
        csr_req.addr  = addr;
        csr_req.wdata = wdata;
        csr_req.write = wr;
        csr_req.valid = 1'b1;
        idle_cycles(1);
        csr_req = '0;
        n = 0;
        while (csr_rsp.valid !== 1'b1 && n < WAIT_LIMIT) begin
            idle_cycles(1);
            n++;
        end
        if (csr_rsp.valid !== 1'b1) begin
            report_timeout("CSR response");
        end
    endtask

    task automatic write_read(input csr_addr_t addr, input word_t w);
        csr_access(addr, 1'b1, w);
        csr_access(addr, 1'b0, '0);
    endtask

    task automatic pulse_event(input logic ebreak, input logic step_done, input logic dret,
                               input word_t pc, input priv_t prv);
        hart_evt.ebreak    = ebreak;
        hart_evt.step_done = step_done;
        hart_evt.dret      = dret;
        hart_evt.pc        = pc;
        hart_evt.prv       = prv;
        idle_cycles(1);
        hart_evt.ebreak    = 1'b0;
        hart_evt.step_done = 1'b0;
        hart_evt.dret      = 1'b0;
    endtask

    task automatic enter_halt(input word_t pc, input priv_t prv);
        hart_evt.pc  = pc;
        hart_evt.prv = prv;
        halt_req     = 1'b1;
        wait_mode(1'b1, "debug entry on halt_req");
        halt_req     = 1'b0;
    endtask

    task automatic leave_debug();
        pulse_event(1'b0, 1'b0, 1'b1, hart_evt.pc, hart_evt.prv);
        wait_resume();
    endtask

    task automatic test_reset_values();
        begin_test();
        enter_halt('0, PRV_M);
        csr_access(DCSR_ADDR, 1'b0, '0);
        csr_access(DPC_ADDR, 1'b0, '0);
        csr_access(DSCRATCH0_ADDR, 1'b0, '0);
        csr_access(DSCRATCH1_ADDR, 1'b0, '0);
        leave_debug();
        finish_test("reset values");
    endtask

    task automatic test_outside_access();
        csr_addr_t a;
        word_t     w;
        begin_test();
        for (a = DCSR_ADDR; a <= DSCRATCH1_ADDR; a++) begin
            rand_word(w);
            write_read(a, w);
        end
        rand_word(w);
        csr_access(12'h300, 1'b1, w);
        csr_access(12'h7b4, 1'b0, '0);
        enter_halt('0, PRV_M);
        csr_access(12'h7b4, 1'b1, w);
        csr_access(12'h341, 1'b0, '0);
        // Contents still at reset values
        csr_access(DSCRATCH0_ADDR, 1'b0, '0);
        csr_access(DSCRATCH1_ADDR, 1'b0, '0);
        leave_debug();
        finish_test("outside debug mode");
    endtask

    task automatic test_halt_entry();
        word_t pc;
        word_t w;
        begin_test();
        rand_word(pc);
        enter_halt(pc, PRV_S);
        csr_access(DCSR_ADDR, 1'b0, '0);
        csr_access(DPC_ADDR, 1'b0, '0);
        repeat (4) begin
            rand_word(w);
            write_read(DSCRATCH0_ADDR, w);
            rand_word(w);
            write_read(DSCRATCH1_ADDR, w);
            rand_word(w);
            write_read(DPC_ADDR, w);
            rand_word(w);
            write_read(DCSR_ADDR, w);
        end
        write_read(DCSR_ADDR, 32'h0000_0001);
        // Reserved prv value 2
        write_read(DCSR_ADDR, 32'hffff_fffe);
        leave_debug();
        finish_test("halt entry");
    endtask

    task automatic test_ebreak_entry();
        word_t pc;
        begin_test();
        enter_halt('0, PRV_M);
        // Only ebreaks set, prv M, no step
        write_read(DCSR_ADDR, 32'h0000_2003);
        leave_debug();
        rand_word(pc);
        pulse_event(1'b1, 1'b0, 1'b0, pc, PRV_U);
        idle_cycles(2);
        pulse_event(1'b1, 1'b0, 1'b0, pc, PRV_M);
        idle_cycles(2);
        rand_word(pc);
        pulse_event(1'b1, 1'b0, 1'b0, pc, PRV_S);
        wait_mode(1'b1, "debug entry on ebreak");
        csr_access(DCSR_ADDR, 1'b0, '0);
        csr_access(DPC_ADDR, 1'b0, '0);
        leave_debug();
        // ebreak and halt_req in the same cycle
        rand_word(pc);
        halt_req = 1'b1;
        pulse_event(1'b1, 1'b0, 1'b0, pc, PRV_S);
        halt_req = 1'b0;
        wait_mode(1'b1, "debug entry on ebreak with halt_req");
        csr_access(DCSR_ADDR, 1'b0, '0);
        leave_debug();
        finish_test("ebreak entry");
    endtask

    task automatic test_single_step();
        word_t pc;
        begin_test();
        enter_halt('0, PRV_M);
        write_read(DCSR_ADDR, 32'h0000_0004);
        leave_debug();
        rand_word(pc);
        pulse_event(1'b0, 1'b1, 1'b0, pc, PRV_U);
        wait_mode(1'b1, "debug entry on single step");
        csr_access(DCSR_ADDR, 1'b0, '0);
        csr_access(DPC_ADDR, 1'b0, '0);
        write_read(DCSR_ADDR, 32'h0000_0003);
        leave_debug();
        finish_test("single step");
    endtask

    task automatic test_resume();
        word_t w;
        begin_test();
        enter_halt('0, PRV_M);
        rand_word(w);
        write_read(DPC_ADDR, w);
        write_read(DCSR_ADDR, 32'h0000_0001);
        leave_debug();
        wait_mode(1'b0, "debug exit");
        // Second dret outside debug mode
        pulse_event(1'b0, 1'b0, 1'b1, w, PRV_S);
        idle_cycles(4);
        finish_test("resume");
    endtask

    initial begin
        csr_req      = '0;
        halt_req     = 1'b0;
        hart_evt     = '0;
        lfsr         = 32'd34;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        wait_reset();
        test_reset_values();
        test_outside_access();
        test_halt_entry();
        test_ebreak_entry();
        test_single_step();
        test_resume();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !hung) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/debug_csr_pkg.sv
logic/csr_access_decode.sv
logic/debug_entry_ctrl.sv
logic/debug_csr_file.sv
logic/debug_resp_port.sv
logic/debug_csr_top.sv
tests/tb_clock_gen.sv
tests/debug_csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= debug_csr_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
